//--- source/platform_pkg.sv
package platform_pkg;

    // Memory map, byte addresses
    localparam logic [31:0] ROM_BASE  = 32'h0000_0000;
    localparam int          ROM_WORDS = 1024;
    localparam logic [31:0] RAM_BASE  = 32'h0000_1000;
    localparam int          RAM_WORDS = 2048;
    localparam int          MEM_WORDS = ROM_WORDS + RAM_WORDS;

    // Single-address I/O ports
    localparam logic [31:0] UART_ADDR = 32'h8000_0000;
    localparam logic [31:0] KEY_ADDR  = 32'h8000_0008;

    // Field view of a bus address
    typedef struct packed {
        logic [15:0] page;
        logic [13:0] word;
        logic [1:0]  lane;
    } bus_addr_fields_t;

    // Same 32 bits, either compared whole or split into fields
    typedef union packed {
        logic [31:0]      raw;
        bus_addr_fields_t f;
    } bus_addr_u;

    // CPU data request
    typedef struct packed {
        logic        read_enable;
        logic        write_enable;
        bus_addr_u   addr;
        logic [63:0] write_data;
    } bus_req_t;

    typedef struct packed {
        logic       valid;
        logic       released;
        logic [7:0] scan;
    } key_event_t;

    typedef struct packed {
        logic       strobe;
        logic [7:0] data;
    } uart_tx_t;

    // Zero vector means no request
    typedef struct packed {
        logic [3:0] vector;
    } irq_t;

endpackage

//--- source/ps2_receiver.sv
`timescale 1ns/10ps

module ps2_receiver
    import platform_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output key_event_t key_event
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_DATA   = 2'd1;
    localparam logic [1:0] ST_PARITY = 2'd2;
    localparam logic [1:0] ST_STOP   = 2'd3;

    localparam logic [7:0] BREAK_CODE = 8'hF0;

    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_prev;
    logic       clk_fall;

    logic [1:0] state;
    logic [2:0] bit_cnt;
    logic [7:0] shift;
    logic       parity_ok;
    logic       release_pending;

    // Bring the PS/2 lines into the board clock domain
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev && !clk_sync[1];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state           <= ST_IDLE;
            bit_cnt         <= 3'd0;
            shift           <= 8'h00;
            parity_ok       <= 1'b0;
            release_pending <= 1'b0;
            key_event       <= '0;
        end else begin
            key_event.valid <= 1'b0;
            if (clk_fall) begin
                case (state)
                    ST_IDLE: begin
                        // Start bit is low
                        if (!dat_sync[1]) begin
                            state   <= ST_DATA;
                            bit_cnt <= 3'd0;
                        end
                    end
                    ST_DATA: begin
                        // LSB first
                        shift   <= {dat_sync[1], shift[7:1]};
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= ST_PARITY;
                        end
                    end
                    ST_PARITY: begin
                        // Odd parity over data plus parity bit
                        parity_ok <= ^{shift, dat_sync[1]};
                        state     <= ST_STOP;
                    end
                    ST_STOP: begin
                        state <= ST_IDLE;
                        if (dat_sync[1] && parity_ok) begin
                            if (shift == BREAK_CODE) begin
                                release_pending <= 1'b1;
                            end else begin
                                key_event.valid    <= 1'b1;
                                key_event.released <= release_pending;
                                key_event.scan     <= shift;
                                release_pending    <= 1'b0;
                            end
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

endmodule

//--- source/step_divider.sv
`timescale 1ns/10ps

module step_divider #(
    parameter int DIVIDE          = 25_000_000,
    parameter int HEARTBEAT_STEPS = 2
) (
    input  logic CLOCK_50,
    input  logic KEY0,
    output logic cpu_step,
    output logic heartbeat_led
);

    localparam int CW = $clog2(DIVIDE + 1);
    localparam int SW = $clog2(HEARTBEAT_STEPS + 1);

    logic [CW-1:0] clk_cnt;
    logic [SW-1:0] step_cnt;
    logic          wrap;

    assign wrap = (clk_cnt == CW'(DIVIDE - 1));

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_cnt       <= '0;
            step_cnt      <= '0;
            cpu_step      <= 1'b0;
            heartbeat_led <= 1'b0;
        end else begin
            cpu_step <= wrap;
            if (wrap) begin
                clk_cnt <= '0;
                // Count steps toward the next heartbeat toggle
                if (step_cnt == SW'(HEARTBEAT_STEPS - 1)) begin
                    step_cnt      <= '0;
                    heartbeat_led <= !heartbeat_led;
                end else begin
                    step_cnt <= step_cnt + 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

endmodule

//--- source/bus_decoder.sv
`timescale 1ns/10ps

module bus_decoder
    import platform_pkg::*;
(
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  bus_req_t    bus_req,
    input  logic [31:0] mem_rdata,
    input  logic [7:0]  key_scan,
    output logic        ram_write,
    output logic [63:0] bus_read_data,
    output uart_tx_t    uart_tx
);

    logic [13:0] rom_off;
    logic [13:0] ram_off;
    logic        rom_sel;
    logic        ram_sel;
    logic        uart_sel;
    logic        key_sel;

    logic        rd_pending;
    logic        rd_mem;
    logic        rd_key;
    logic [7:0]  key_q;
    logic [63:0] rd_hold;
    logic [63:0] rd_sel;

    logic        uart_wr;
    logic        uart_wr_q;

    // Memory regions from the field view, offsets wrap below the base
    assign rom_off = bus_req.addr.f.word - ROM_BASE[15:2];
    assign ram_off = bus_req.addr.f.word - RAM_BASE[15:2];
    assign rom_sel = (bus_req.addr.f.page == ROM_BASE[31:16]) && (rom_off < 14'(ROM_WORDS));
    assign ram_sel = (bus_req.addr.f.page == RAM_BASE[31:16]) && (ram_off < 14'(RAM_WORDS));

    // I/O ports match one exact address
    assign uart_sel = (bus_req.addr.raw == UART_ADDR);
    assign key_sel  = (bus_req.addr.raw == KEY_ADDR);

    // ROM is read-only
    assign ram_write = bus_req.write_enable && ram_sel;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_pending <= 1'b0;
            rd_mem     <= 1'b0;
            rd_key     <= 1'b0;
            rd_hold    <= 64'd0;
            uart_wr_q  <= 1'b0;
        end else begin
            rd_pending <= bus_req.read_enable;
            if (bus_req.read_enable) begin
                rd_mem <= rom_sel || ram_sel;
                rd_key <= key_sel;
            end
            rd_hold   <= bus_read_data;
            uart_wr_q <= uart_wr;
        end
    end

    // Scan code sampled together with the read
    always_ff @(posedge CLOCK_50) begin
        if (bus_req.read_enable) begin
            key_q <= key_scan;
        end
    end

    // Memory word arrives one cycle after the read
    always_comb begin
        if (rd_mem) begin
            rd_sel = {32'd0, mem_rdata};
        end else if (rd_key) begin
            rd_sel = {56'd0, key_q};
        end else begin
            rd_sel = 64'd0;
        end
    end

    assign bus_read_data = rd_pending ? rd_sel : rd_hold;

    // First cycle of a run of UART writes
    assign uart_wr        = bus_req.write_enable && uart_sel;
    assign uart_tx.strobe = uart_wr && !uart_wr_q;
    assign uart_tx.data   = bus_req.write_data[7:0];

endmodule

//--- source/unified_memory.sv
`timescale 1ns/10ps

module unified_memory
    import platform_pkg::*;
(
    input  logic        CLOCK_50,
    input  bus_req_t    bus_req,
    input  logic        ram_write,
    input  logic [31:0] fetch_addr,
    output logic [31:0] mem_rdata,
    output logic [31:0] fetch_word
);

    localparam int AW = $clog2(MEM_WORDS);

    logic [31:0] mem [0:MEM_WORDS-1];
    bus_addr_u   fetch_a;
    logic [31:0] fetch_q;

    // Unused RAM reads as zero, boot image at the ROM base
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'd0;
        end
        $readmemh("rom.hex", mem, ROM_BASE >> 2);
    end

    assign fetch_a = fetch_addr;

    // Data port, read returns the old word on a same-cycle write
    always_ff @(posedge CLOCK_50) begin
        if (ram_write) begin
            mem[bus_req.addr.f.word[AW-1:0]] <= bus_req.write_data[31:0];
        end
        mem_rdata <= mem[bus_req.addr.f.word[AW-1:0]];
    end

    // Fetch port
    always_ff @(posedge CLOCK_50) begin
        fetch_q <= mem[fetch_a.f.word[AW-1:0]];
    end

    // Instruction words are stored big-endian
    assign fetch_word = {fetch_q[7:0], fetch_q[15:8], fetch_q[23:16], fetch_q[31:24]};

endmodule

//--- source/key_interrupt.sv
`timescale 1ns/10ps

module key_interrupt
    import platform_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  key_event_t key_event,
    input  logic       irq_ack,
    output logic [7:0] key_scan,
    output irq_t       irq,
    output logic       irq_led
);

    localparam logic [3:0] KEY_VECTOR = 4'd1;

    logic new_make;
    logic ack_seen;

    // Only presses raise the interrupt, releases are ignored
    assign new_make = key_event.valid && !key_event.released && (key_event.scan != 8'h00);
    assign ack_seen = irq_ack && (irq.vector != 4'd0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_scan   <= 8'h00;
            irq.vector <= 4'd0;
        end else begin
            if (new_make) begin
                // A fresh press outranks a pending acknowledge
                key_scan   <= key_event.scan;
                irq.vector <= KEY_VECTOR;
            end else if (ack_seen) begin
                irq.vector <= 4'd0;
            end
        end
    end

    assign irq_led = (irq.vector != 4'd0);

endmodule

//--- source/board_platform.sv
`timescale 1ns/10ps

module board_platform
    import platform_pkg::*;
#(
    parameter int DIVIDE          = 25_000_000,
    parameter int HEARTBEAT_STEPS = 2
) (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  bus_req_t    bus_req,
    output logic [63:0] bus_read_data,
    input  logic [31:0] fetch_addr,
    output logic [31:0] fetch_word,
    output irq_t        irq,
    input  logic        irq_ack,
    output logic        cpu_step,
    input  logic        ps2_clk,
    input  logic        ps2_dat,
    output logic        heartbeat_led,
    output logic        irq_led,
    output uart_tx_t    uart_tx
);

    key_event_t  key_event;
    logic [7:0]  key_scan;
    logic        ram_write;
    logic [31:0] mem_rdata;

    ps2_receiver u_ps2 (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .ps2_clk   (ps2_clk),
        .ps2_dat   (ps2_dat),
        .key_event (key_event)
    );

    step_divider #(
        .DIVIDE          (DIVIDE),
        .HEARTBEAT_STEPS (HEARTBEAT_STEPS)
    ) u_step (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .cpu_step      (cpu_step),
        .heartbeat_led (heartbeat_led)
    );

    bus_decoder u_bus (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .bus_req       (bus_req),
        .mem_rdata     (mem_rdata),
        .key_scan      (key_scan),
        .ram_write     (ram_write),
        .bus_read_data (bus_read_data),
        .uart_tx       (uart_tx)
    );

    unified_memory u_mem (
        .CLOCK_50   (CLOCK_50),
        .bus_req    (bus_req),
        .ram_write  (ram_write),
        .fetch_addr (fetch_addr),
        .mem_rdata  (mem_rdata),
        .fetch_word (fetch_word)
    );

    key_interrupt u_irq (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .key_event (key_event),
        .irq_ack   (irq_ack),
        .key_scan  (key_scan),
        .irq       (irq),
        .irq_led   (irq_led)
    );

endmodule

//--- tb/ps2_host_tasks.svh
`ifndef PS2_HOST_TASKS_SVH
`define PS2_HOST_TASKS_SVH

// Clocks per PS/2 clock half period
localparam int PS2_HALF = 4;

// Cycles one frame takes on the wire plus settling time
localparam int FRAME_CYCLES = 11 * (2 * PS2_HALF + 3) + 9;

task automatic hold_cycles(input int n);
    repeat (n) @(posedge CLOCK_50);
endtask

// Start bit, 8 data bits LSB first, odd parity, stop bit
task automatic send_ps2_frame(input logic [7:0] code, input logic bad_parity);
    logic [10:0] bits;
    logic        parity;
    parity = (~^code) ^ bad_parity;
    bits   = {1'b1, parity, code, 1'b0};
    for (int i = 0; i < 11; i++) begin
        @(posedge CLOCK_50);
        ps2_dat <= bits[i];
        hold_cycles(PS2_HALF);
        @(posedge CLOCK_50);
        ps2_clk <= 1'b0;
        hold_cycles(PS2_HALF);
        @(posedge CLOCK_50);
        ps2_clk <= 1'b1;
    end
    @(posedge CLOCK_50);
    ps2_dat <= 1'b1;
    // Let the receiver finish the frame
    hold_cycles(8);
endtask

// Key release as seen on the wire
task automatic send_ps2_release(input logic [7:0] code);
    send_ps2_frame(8'hF0, 1'b0);
    send_ps2_frame(code, 1'b0);
endtask

// Any scan code except zero and the break prefix
function automatic logic [7:0] pick_scan(input logic [31:0] r);
    logic [7:0] s;
    s = r[7:0];
    if (s == 8'h00 || s == 8'hF0) begin
        s = 8'h1C;
    end
    return s;
endfunction

`endif

//--- tb/board_platform_tb.sv
`timescale 1ns/10ps

module board_platform_tb
    import platform_pkg::*;
;

    localparam int N_MEM   = 300;
    localparam int N_FETCH = 100;
    localparam int N_KEY   = 10;
    localparam int N_UART  = 20;

    logic        CLOCK_50;
    logic        KEY0;
    bus_req_t    bus_req;
    logic [63:0] bus_read_data;
    logic [31:0] fetch_addr;
    logic [31:0] fetch_word;
    irq_t        irq;
    logic        irq_ack;
    logic        cpu_step;
    logic        ps2_clk;
    logic        ps2_dat;
    logic        heartbeat_led;
    logic        irq_led;
    uart_tx_t    uart_tx;

    logic [31:0] shadow [0:3071];
    logic [7:0]  exp_scan;
    integer      seed;
    int          cycles;
    int          cyc_no;
    int          last_step;
    int          steps;
    logic        exp_hb;

    `include "ps2_host_tasks.svh"

    localparam int LIMIT = 2 * (8 + 3 * N_MEM + 3 * N_FETCH + N_KEY * (4 * FRAME_CYCLES + 80)
                                + 6 * N_UART + 300);

    board_platform #(
        .DIVIDE          (16),
        .HEARTBEAT_STEPS (4)
    ) uut (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .bus_req       (bus_req),
        .bus_read_data (bus_read_data),
        .fetch_addr    (fetch_addr),
        .fetch_word    (fetch_word),
        .irq           (irq),
        .irq_ack       (irq_ack),
        .cpu_step      (cpu_step),
        .ps2_clk       (ps2_clk),
        .ps2_dat       (ps2_dat),
        .heartbeat_led (heartbeat_led),
        .irq_led       (irq_led),
        .uart_tx       (uart_tx)
    );

    always #5 CLOCK_50 = ~CLOCK_50;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        stop_with_error($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic drive_bus(input logic re, input logic we, input logic [31:0] addr,
                             input logic [63:0] data);
        @(posedge CLOCK_50);
        bus_req <= {re, we, addr, data};
    endtask

    // Issue a read, then sample the result one clock later
    task automatic read_check(input logic [31:0] addr, input logic [63:0] exp);
        drive_bus(1'b1, 1'b0, addr, 64'd0);
        drive_bus(1'b0, 1'b0, 32'd0, 64'd0);
        @(negedge CLOCK_50);
        assert (bus_read_data == exp) else report_mismatch("bus_read_data", bus_read_data, exp);
    endtask

    function automatic logic [31:0] mem_addr(input logic to_ram, input logic [31:0] r);
        if (to_ram) begin
            return 32'h1000 + {19'd0, r[10:0], 2'b00};
        end
        return {20'd0, r[9:0], 2'b00};
    endfunction

    // Byte 0 of the stored word lands in the top byte of the fetch word
    function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
        logic [31:0] v;
        for (int b = 0; b < 4; b++) begin
            v[8*b +: 8] = w[8*(3-b) +: 8];
        end
        return v;
    endfunction

    // Step spacing and heartbeat toggles over the whole run
    always @(negedge CLOCK_50) begin
        if (KEY0) begin
            cyc_no++;
            if (cpu_step) begin
                if (steps > 0) begin
                    assert (cyc_no - last_step == 16)
                    else report_mismatch("cpu_step period", 64'(cyc_no - last_step), 64'd16);
                end
                last_step = cyc_no;
                steps++;
                if (steps % 4 == 0) begin
                    exp_hb = ~exp_hb;
                end
            end
            assert (heartbeat_led == exp_hb)
            else report_mismatch("heartbeat_led", 64'(heartbeat_led), 64'(exp_hb));
        end
    end

    always @(posedge CLOCK_50) begin
        cycles++;
        if (cycles >= LIMIT) begin
            stop_with_error("Timeout: the run went past its cycle limit");
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] w;
        logic [63:0] d;
        logic [7:0]  s;
        int          len;
        int          wait_n;
        CLOCK_50 = 1'b0;
        KEY0 = 1'b0;
        bus_req = '0;
        fetch_addr = 32'd0;
        irq_ack = 1'b0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        seed = 32'hf843_7dee;
        cycles = 0;
        cyc_no = 0;
        last_step = 0;
        steps = 0;
        exp_hb = 1'b0;
        exp_scan = 8'h00;
        for (int i = 0; i < 3072; i++) begin
            shadow[i] = 32'd0;
        end
        $readmemh("rom.hex", shadow);
        hold_cycles(8);
        KEY0 <= 1'b1;
        hold_cycles(2);

        // Random memory traffic where ROM writes are dropped
        for (int i = 0; i < N_MEM; i++) begin
            r = $random(seed);
            a = mem_addr(r[31], $random(seed));
            if (r[30]) begin
                d = {$random(seed), $random(seed)};
                drive_bus(1'b0, 1'b1, a, d);
                if (r[31]) begin
                    shadow[a[13:2]] = d[31:0];
                end
                drive_bus(1'b0, 1'b0, 32'd0, 64'd0);
            end else begin
                read_check(a, {32'd0, shadow[a[13:2]]});
            end
        end

        for (int i = 0; i < N_FETCH; i++) begin
            r = $random(seed);
            a = {18'd0, r[11:0] % 12'd3072, 2'b00};
            @(posedge CLOCK_50);
            fetch_addr <= a;
            @(posedge CLOCK_50);
            @(negedge CLOCK_50);
            w = reverse_bytes(shadow[a[13:2]]);
            assert (fetch_word == w) else report_mismatch("fetch_word", 64'(fetch_word), 64'(w));
        end

        for (int i = 0; i < N_KEY; i++) begin
            s = pick_scan($random(seed));
            send_ps2_frame(s, 1'b0);
            exp_scan = s;
            wait_n = 0;
            @(negedge CLOCK_50);
            while (irq.vector != 4'd1 && wait_n < 40) begin
                @(negedge CLOCK_50);
                wait_n++;
            end
            assert (irq.vector == 4'd1)
            else report_mismatch("irq.vector", 64'(irq.vector), 64'd1);
            assert (irq_led == 1'b1) else report_mismatch("irq_led", 64'(irq_led), 64'd1);
            read_check(KEY_ADDR, {56'd0, exp_scan});
            @(posedge CLOCK_50);
            irq_ack <= 1'b1;
            @(posedge CLOCK_50);
            irq_ack <= 1'b0;
            @(negedge CLOCK_50);
            assert (irq.vector == 4'd0)
            else report_mismatch("irq.vector", 64'(irq.vector), 64'd0);
            assert (irq_led == 1'b0) else report_mismatch("irq_led", 64'(irq_led), 64'd0);
            // Releases and corrupt frames leave everything alone
            send_ps2_release(pick_scan($random(seed)));
            send_ps2_frame(pick_scan($random(seed)), 1'b1);
            hold_cycles(4);
            @(negedge CLOCK_50);
            assert (irq.vector == 4'd0)
            else report_mismatch("irq.vector", 64'(irq.vector), 64'd0);
            read_check(KEY_ADDR, {56'd0, exp_scan});
        end

        for (int i = 0; i < N_UART; i++) begin
            r = $random(seed);
            len = 1 + int'(r[1:0]);
            for (int k = 0; k < len; k++) begin
                d = {$random(seed), $random(seed)};
                drive_bus(1'b0, 1'b1, UART_ADDR, d);
                @(negedge CLOCK_50);
                assert (uart_tx.strobe == (k == 0))
                else report_mismatch("uart_tx.strobe", 64'(uart_tx.strobe), 64'(k == 0));
                if (k == 0) begin
                    assert (uart_tx.data == d[7:0])
                    else report_mismatch("uart_tx.data", 64'(uart_tx.data), 64'(d[7:0]));
                end
            end
            drive_bus(1'b0, 1'b0, 32'd0, 64'd0);
            @(negedge CLOCK_50);
            assert (uart_tx.strobe == 1'b0)
            else report_mismatch("uart_tx.strobe", 64'(uart_tx.strobe), 64'd0);
        end

        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            a = r[0] ? {16'h4000 | r[31:16], r[15:2], 2'b00}
                     : 32'h3000 + {20'd0, r[11:2], 2'b00};
            read_check(a, 64'd0);
        end

        // A few heartbeat periods
        hold_cycles(200);
        if (steps >= 8) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            stop_with_error("Too few cpu_step pulses were seen");
        end
    end

endmodule

//--- rom.hex
// Boot ROM image, one 32-bit word per line in hex
// Lines map to word addresses 0 upward
00000297
02028293
30529073
00001137
ff010113
00000517
0f050513
000015b7
00b52023
00100613
00c5a223
0005a683
fe068ee3
10500073
0000006f
deadbeef

//--- board_platform.f
+incdir+tb
source/platform_pkg.sv
source/ps2_receiver.sv
source/step_divider.sv
source/bus_decoder.sv
source/unified_memory.sv
source/key_interrupt.sv
source/board_platform.sv
tb/board_platform_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the board platform testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f board_platform.f \
    --top-module board_platform_tb -o board_platform_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/board_platform_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    exit 1
fi
exit 0
